// ==== include/mem_ctrl_params.svh ====
`ifndef MEM_CTRL_PARAMS_SVH
`define MEM_CTRL_PARAMS_SVH

// Console and PSRAM address widths
`define SNES_ADDR_W 24
`define ROM_ADDR_W 23

// Strobe shift register length, strobe patterns are written for 8
`define SYNC_DEPTH 8

// Address pipeline stages
`define ADDR_SYNC_DEPTH 6

// Extra clocks the MCU holds the PSRAM for one access
`define ROM_CYCLE_LEN 7

// Idle clocks before the console counts as dead, about 1 ms
`define SNES_DEAD_TIMEOUT 88000

// PSRAM byte address of the save RAM window
`define SAVERAM_BASE 24'hE00000

`endif

// ==== design/mem_ctrl_pkg.sv ====
`include "mem_ctrl_params.svh"

package mem_ctrl_pkg;

  typedef enum logic [1:0] {
    map_hirom = 2'b00,
    map_lorom = 2'b01
  } mapper_e;

  // Mapper setup from the MCU
  typedef struct packed {
    mapper_e                 mapper;
    logic [`SNES_ADDR_W-1:0] rom_mask;
    logic [`SNES_ADDR_W-1:0] saveram_mask;
  } map_cfg_t;

  typedef struct packed {
    logic                    read_n;       // Debounced levels
    logic                    write_n;
    logic                    cpu_clk;
    logic                    rd_start;     // One-clock pulses
    logic                    rd_end;
    logic                    wr_end;
    logic                    cycle_start;
    logic                    cycle_end;
    logic [`SNES_ADDR_W-1:0] addr;
  } snes_bus_t;

  typedef struct packed {
    logic                    rom_hit;      // ROM or save RAM
    logic                    is_rom;
    logic                    is_saveram;
    logic                    is_writable;
    logic [`SNES_ADDR_W-1:0] addr;         // PSRAM byte address
  } map_res_t;

  typedef struct packed {
    logic                    rrq;
    logic                    wrq;
    logic [`SNES_ADDR_W-1:0] addr;
    logic [7:0]              wdata;
  } mcu_req_t;

  typedef struct packed {
    logic [7:0] hi;
    logic [7:0] lo;
  } rom_bytes_t;

  // PSRAM data seen as a word or as two byte lanes
  typedef union packed {
    logic [15:0] word;
    rom_bytes_t  lanes;
  } rom_word_u;

endpackage

// ==== design/snes_bus_sync.sv ====
`timescale 1ns/100ps
`include "mem_ctrl_params.svh"

module snes_bus_sync import mem_ctrl_pkg::*; (
  input  logic                    CLK2,
  input  logic                    rst_n,
  input  logic [`SNES_ADDR_W-1:0] addr_in,
  input  logic                    read_n_in,
  input  logic                    write_n_in,
  input  logic                    cpu_clk_in,
  output snes_bus_t               bus
);

  logic [`SYNC_DEPTH-1:0]  read_sr;
  logic [`SYNC_DEPTH-1:0]  write_sr;
  logic [`SYNC_DEPTH-3:0]  clk_sr;     // Shorter, cycle edges need fewer stages
  logic [`SNES_ADDR_W-1:0] addr_pipe [`ADDR_SYNC_DEPTH];

  //////////////////////////////////////////////////////////////////////
  // Strobe shift registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      read_sr  <= '1;                  // Console strobes idle high
      write_sr <= '1;
      clk_sr   <= '0;
    end else begin
      read_sr  <= {read_sr[`SYNC_DEPTH-2:0], read_n_in};
      write_sr <= {write_sr[`SYNC_DEPTH-2:0], write_n_in};
      clk_sr   <= {clk_sr[`SYNC_DEPTH-4:0], cpu_clk_in};
    end
  end

  // Address settles well before the strobes, so a plain pipeline does
  always_ff @(posedge CLK2) begin
    addr_pipe[0] <= addr_in;
    for (int i = 1; i < `ADDR_SYNC_DEPTH; i++) begin
      addr_pipe[i] <= addr_pipe[i-1];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Levels and edge pulses
  //////////////////////////////////////////////////////////////////////

  // Adjacent stages are combined to filter single-clock glitches.
  // A falling edge shows as ones above zeros after OR of neighbours,
  // a rising edge as zeros above ones after AND of neighbours.
  always_comb begin
    bus.read_n      = read_sr[2] & read_sr[1];
    bus.write_n     = write_sr[2] & write_sr[1];
    bus.cpu_clk     = clk_sr[2] & clk_sr[1];

    bus.rd_start    = ((read_sr[6:1] | read_sr[7:2]) == 6'b111110);
    bus.rd_end      = ((read_sr[6:1] & read_sr[7:2]) == 6'b000001);
    bus.wr_end      = ((write_sr[6:1] & write_sr[7:2]) == 6'b000001);
    bus.cycle_start = ((clk_sr[5:2] & clk_sr[4:1]) == 4'b0001);  // CPU clock rise
    bus.cycle_end   = ((clk_sr[5:2] | clk_sr[4:1]) == 4'b1110);  // CPU clock fall

    // Last two stages must agree bitwise
    bus.addr = addr_pipe[`ADDR_SYNC_DEPTH-1] & addr_pipe[`ADDR_SYNC_DEPTH-2];
  end

endmodule

// ==== design/snes_alive_monitor.sv ====
`timescale 1ns/100ps
`include "mem_ctrl_params.svh"

module snes_alive_monitor import mem_ctrl_pkg::*; #(
  parameter int unsigned DEAD_TIMEOUT = `SNES_DEAD_TIMEOUT
) (
  input  logic      CLK2,
  input  logic      rst_n,
  input  snes_bus_t bus,
  output logic      snes_dead
);

  localparam int CNT_W = 18;

  logic [CNT_W-1:0] idle_cnt;
  logic             timed_out;

  assign timed_out = (idle_cnt > CNT_W'(DEAD_TIMEOUT));

  // Only the CPU clock counts as a sign of life
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      idle_cnt <= '0;
    end else if (bus.cpu_clk) begin
      idle_cnt <= '0;
    end else if (!timed_out) begin
      idle_cnt <= idle_cnt + 1'b1;     // Stops just past the limit
    end
  end

  // Dead until the console shows a clock
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      snes_dead <= 1'b1;
    end else if (bus.cpu_clk) begin
      snes_dead <= 1'b0;
    end else if (timed_out) begin
      snes_dead <= 1'b1;
    end
  end

endmodule

// ==== design/snes_addr_map.sv ====
`timescale 1ns/100ps
`include "mem_ctrl_params.svh"

module snes_addr_map import mem_ctrl_pkg::*; (
  input  logic [`SNES_ADDR_W-1:0] addr,
  input  map_cfg_t                cfg,
  output map_res_t                res
);

  logic                    hi_sram;
  logic                    hi_rom;
  logic                    lo_sram;
  logic                    lo_rom;
  logic [`SNES_ADDR_W-1:0] hi_sram_addr;
  logic [`SNES_ADDR_W-1:0] hi_rom_addr;
  logic [`SNES_ADDR_W-1:0] lo_sram_addr;
  logic [`SNES_ADDR_W-1:0] lo_rom_addr;

  //////////////////////////////////////////////////////////////////////
  // HiROM
  //////////////////////////////////////////////////////////////////////

  // Banks 20-3F and A0-BF, offsets 6000-7FFF
  assign hi_sram = ~addr[22] & addr[21] & (addr[15:13] == 3'b011);

  // Upper half of the map plus upper offsets, WRAM banks 7E-7F excluded
  assign hi_rom = (addr[22] | addr[15]) & (addr[23:17] != 7'b0111111);

  assign hi_sram_addr = `SAVERAM_BASE
                      + ({6'd0, addr[20:16], addr[12:0]} & cfg.saveram_mask);
  assign hi_rom_addr  = {2'b00, addr[21:0]} & cfg.rom_mask;

  //////////////////////////////////////////////////////////////////////
  // LoROM
  //////////////////////////////////////////////////////////////////////

  // Banks 70-7D and F0-FF, lower offsets
  assign lo_sram = (addr[22:20] == 3'b111) & ~addr[15]
                 & (addr[23] | (addr[19:17] != 3'b111));

  assign lo_rom = addr[15];          // 32K pages in the upper half

  assign lo_sram_addr = `SAVERAM_BASE
                      + ({5'd0, addr[19:16], addr[14:0]} & cfg.saveram_mask);
  assign lo_rom_addr  = {2'b00, addr[22:16], addr[14:0]} & cfg.rom_mask;

  // Result select
  always_comb begin
    if (cfg.mapper == map_lorom) begin
      res.is_saveram = lo_sram;
      res.is_rom     = lo_rom;
      res.addr       = lo_sram ? lo_sram_addr : lo_rom_addr;
    end else begin
      res.is_saveram = hi_sram;
      res.is_rom     = hi_rom;
      res.addr       = hi_sram ? hi_sram_addr : hi_rom_addr;
    end
    res.is_writable = res.is_saveram;  // ROM stays read-only
    res.rom_hit     = res.is_rom | res.is_saveram;
  end

endmodule

// ==== design/mcu_rom_arbiter.sv ====
`timescale 1ns/100ps
`include "mem_ctrl_params.svh"

module mcu_rom_arbiter import mem_ctrl_pkg::*; (
  input  logic                    CLK2,
  input  logic                    rst_n,
  input  snes_bus_t               bus,
  input  map_res_t                map,
  input  logic                    snes_dead,
  input  mcu_req_t                req,
  input  rom_word_u               rom_rdata,
  output logic                    mcu_rdy,
  output logic [7:0]              mcu_rdata,
  output logic [`SNES_ADDR_W-1:0] mcu_addr,
  output logic [7:0]              mcu_wdata,
  output logic                    mcu_active,
  output logic                    mcu_wr_active
);

  // One-hot access states
  localparam logic [4:0] st_idle    = 5'b00001;
  localparam logic [4:0] st_rd_addr = 5'b00010;
  localparam logic [4:0] st_rd_end  = 5'b00100;
  localparam logic [4:0] st_wr_addr = 5'b01000;
  localparam logic [4:0] st_wr_end  = 5'b10000;

  logic [4:0] state;
  logic [3:0] delay_cnt;
  logic       rd_pend;
  logic       wr_pend;
  logic       free_strobe;
  logic       free_slot;
  logic       acc_done;
  logic       wake_up;

  assign free_slot     = bus.cycle_end | free_strobe;
  assign acc_done      = |(state & (st_rd_end | st_wr_end));
  assign wake_up       = snes_dead & bus.cpu_clk;   // Console just came back
  assign mcu_active    = |(state & (st_rd_addr | st_wr_addr));
  assign mcu_wr_active = |(state & st_wr_addr);

  //////////////////////////////////////////////////////////////////////
  // Request side
  //////////////////////////////////////////////////////////////////////

  // Console cycle that does not touch the PSRAM frees the next clock
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= bus.cycle_start & ~map.rom_hit;
    end
  end

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (req.rrq) begin
      rd_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (req.wrq) begin
      wr_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (acc_done) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (req.rrq | req.wrq) mcu_addr <= req.addr;
    if (req.wrq) mcu_wdata <= req.wdata;
    // Keeps sampling until the read window closes, last sample wins
    if (state == st_rd_addr) begin
      mcu_rdata <= mcu_addr[0] ? rom_rdata.lanes.lo : rom_rdata.lanes.hi;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Access FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      state     <= st_idle;
      delay_cnt <= '0;
    end else if (wake_up) begin
      state <= st_idle;                // Abort, pending flag forces a retry
    end else begin
      case (state)
        st_idle: begin
          if (free_slot | snes_dead) begin
            if (rd_pend) begin
              state     <= st_rd_addr;
              delay_cnt <= 4'(`ROM_CYCLE_LEN);
            end else if (wr_pend) begin
              state     <= st_wr_addr;
              delay_cnt <= 4'(`ROM_CYCLE_LEN);
            end
          end
        end
        st_rd_addr: begin
          delay_cnt <= delay_cnt - 1'b1;
          if (delay_cnt == '0) state <= st_rd_end;
        end
        st_wr_addr: begin
          delay_cnt <= delay_cnt - 1'b1;
          if (delay_cnt == '0) state <= st_wr_end;
        end
        default: state <= st_idle;     // Both end states
      endcase
    end
  end

endmodule

// ==== design/psram_bus_mux.sv ====
`timescale 1ns/100ps
`include "mem_ctrl_params.svh"

module psram_bus_mux import mem_ctrl_pkg::*; (
  input  snes_bus_t               bus,
  input  map_res_t                map,
  input  logic [7:0]              snes_data_in,
  input  logic                    snes_cs_n,
  input  logic                    mcu_active,
  input  logic                    mcu_wr_active,
  input  logic [`SNES_ADDR_W-1:0] mcu_addr,
  input  logic [7:0]              mcu_wdata,
  input  rom_word_u               rom_rdata,
  output logic [`ROM_ADDR_W-1:0]  rom_addr,
  output rom_word_u               rom_wdata,
  output logic                    rom_data_oe,
  output logic                    rom_we_n,
  output logic                    rom_bhe_n,
  output logic                    rom_ble_n,
  output logic [7:0]              snes_data_out,
  output logic                    snes_data_oe,
  output logic                    snes_databus_oe_n,
  output logic                    snes_databus_dir
);

  logic [`SNES_ADDR_W-1:0] sel_addr;
  logic                    a0;
  logic                    snes_wr_hit;
  logic                    snes_wr_sram;
  logic                    snes_acc;
  logic [7:0]              wr_byte;

  //////////////////////////////////////////////////////////////////////
  // PSRAM side
  //////////////////////////////////////////////////////////////////////

  assign sel_addr  = mcu_active ? mcu_addr : map.addr;
  assign a0        = sel_addr[0];
  assign rom_addr  = sel_addr[`SNES_ADDR_W-1:1];  // Word address
  assign rom_bhe_n = a0;                          // Even byte on the high lane
  assign rom_ble_n = ~a0;

  assign snes_wr_hit  = map.rom_hit & ~bus.write_n;
  assign snes_wr_sram = map.is_writable & bus.cpu_clk & ~bus.write_n;

  // MCU owns the bus while its access runs
  assign wr_byte = mcu_wr_active ? mcu_wdata : snes_data_in;

  always_comb begin
    rom_wdata.word = a0 ? {8'h00, wr_byte} : {wr_byte, 8'h00};
  end

  assign rom_data_oe = mcu_wr_active | (snes_wr_hit & ~mcu_active);
  assign rom_we_n    = ~(mcu_wr_active | (snes_wr_sram & ~mcu_active));

  //////////////////////////////////////////////////////////////////////
  // Console side
  //////////////////////////////////////////////////////////////////////

  assign snes_data_out = a0 ? rom_rdata.lanes.lo : rom_rdata.lanes.hi;
  assign snes_data_oe  = ~bus.read_n & map.rom_hit;

  // ROM needs the console's chip select, save RAM decodes on its own
  assign snes_acc          = ~bus.read_n | ~bus.write_n;
  assign snes_databus_oe_n = ~(((map.is_rom & ~snes_cs_n) | map.is_saveram) & snes_acc);
  assign snes_databus_dir  = ~bus.read_n;  // High drives toward the console

endmodule

// ==== design/mem_ctrl_top.sv ====
`timescale 1ns/100ps
`include "mem_ctrl_params.svh"

module mem_ctrl_top import mem_ctrl_pkg::*; #(
  parameter int unsigned DEAD_TIMEOUT = `SNES_DEAD_TIMEOUT
) (
  input  logic                    CLK2,
  input  logic                    rst_n,
  // Console bus
  input  logic [`SNES_ADDR_W-1:0] snes_addr_in,
  input  logic                    snes_read_n_in,
  input  logic                    snes_write_n_in,
  input  logic                    snes_cpu_clk_in,
  input  logic                    snes_cs_n,
  input  logic [7:0]              snes_data_in,
  output logic [7:0]              snes_data_out,
  output logic                    snes_data_oe,
  output logic                    snes_databus_oe_n,
  output logic                    snes_databus_dir,
  // MCU
  input  map_cfg_t                map_cfg,
  input  mcu_req_t                mcu_req,
  output logic                    mcu_rdy,
  output logic [7:0]              mcu_rdata,
  // PSRAM
  output logic [`ROM_ADDR_W-1:0]  rom_addr,
  output rom_word_u               rom_wdata,
  input  rom_word_u               rom_rdata,
  output logic                    rom_data_oe,
  output logic                    rom_we_n,
  output logic                    rom_bhe_n,
  output logic                    rom_ble_n
);

  snes_bus_t               bus;
  map_res_t                map_res;
  logic                    snes_dead;
  logic [`SNES_ADDR_W-1:0] mcu_addr;
  logic [7:0]              mcu_wdata;
  logic                    mcu_active;
  logic                    mcu_wr_active;

  snes_bus_sync u_bus_sync (
    .CLK2       (CLK2),
    .rst_n      (rst_n),
    .addr_in    (snes_addr_in),
    .read_n_in  (snes_read_n_in),
    .write_n_in (snes_write_n_in),
    .cpu_clk_in (snes_cpu_clk_in),
    .bus        (bus)
  );

  snes_alive_monitor #(
    .DEAD_TIMEOUT (DEAD_TIMEOUT)
  ) u_alive (
    .CLK2      (CLK2),
    .rst_n     (rst_n),
    .bus       (bus),
    .snes_dead (snes_dead)
  );

  snes_addr_map u_addr_map (
    .addr (bus.addr),
    .cfg  (map_cfg),
    .res  (map_res)
  );

  mcu_rom_arbiter u_arbiter (
    .CLK2          (CLK2),
    .rst_n         (rst_n),
    .bus           (bus),
    .map           (map_res),
    .snes_dead     (snes_dead),
    .req           (mcu_req),
    .rom_rdata     (rom_rdata),
    .mcu_rdy       (mcu_rdy),
    .mcu_rdata     (mcu_rdata),
    .mcu_addr      (mcu_addr),
    .mcu_wdata     (mcu_wdata),
    .mcu_active    (mcu_active),
    .mcu_wr_active (mcu_wr_active)
  );

  psram_bus_mux u_bus_mux (
    .bus               (bus),
    .map               (map_res),
    .snes_data_in      (snes_data_in),
    .snes_cs_n         (snes_cs_n),
    .mcu_active        (mcu_active),
    .mcu_wr_active     (mcu_wr_active),
    .mcu_addr          (mcu_addr),
    .mcu_wdata         (mcu_wdata),
    .rom_rdata         (rom_rdata),
    .rom_addr          (rom_addr),
    .rom_wdata         (rom_wdata),
    .rom_data_oe       (rom_data_oe),
    .rom_we_n          (rom_we_n),
    .rom_bhe_n         (rom_bhe_n),
    .rom_ble_n         (rom_ble_n),
    .snes_data_out     (snes_data_out),
    .snes_data_oe      (snes_data_oe),
    .snes_databus_oe_n (snes_databus_oe_n),
    .snes_databus_dir  (snes_databus_dir)
  );

endmodule

// ==== tests/psram_model.sv ====
`timescale 1ns/100ps
`include "mem_ctrl_params.svh"

module psram_model import mem_ctrl_pkg::*; (
  input  logic                   CLK2,
  input  logic [`ROM_ADDR_W-1:0] addr,
  input  rom_word_u              wdata,
  input  logic                   we_n,
  input  logic                   bhe_n,
  input  logic                   ble_n,
  output rom_word_u              rdata
);

  // Sparse storage, only touched words exist
  logic [15:0] mem [logic [`ROM_ADDR_W-1:0]];

  // Contents of a word never written
  function automatic logic [15:0] fill_word(input logic [`ROM_ADDR_W-1:0] a);
    return a[15:0] ^ {a[22:16], a[22:14]} ^ 16'hA5C3;
  endfunction

  // Backdoor access for checks and preload
  function automatic logic [15:0] peek_word(input logic [`ROM_ADDR_W-1:0] a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return fill_word(a);
  endfunction

  task automatic poke_word(input logic [`ROM_ADDR_W-1:0] a, input logic [15:0] w);
    mem[a] = w;
  endtask

  // Read data lags the address by one clock
  always @(posedge CLK2) begin
    rom_word_u cur;
    cur.word = peek_word(addr);
    rdata <= cur;
    if (!we_n) begin
      if (!bhe_n) cur.lanes.hi = wdata.lanes.hi;   // Even byte
      if (!ble_n) cur.lanes.lo = wdata.lanes.lo;
      mem[addr] = cur.word;
    end
  end

endmodule

// ==== tests/tb_mem_ctrl.sv ====
`timescale 1ns/100ps
`include "mem_ctrl_params.svh"

module tb_mem_ctrl import mem_ctrl_pkg::*; ();

  localparam int unsigned TB_DEAD_TIMEOUT = 200;
  localparam int          NUM_ROWS        = 17;
  localparam int unsigned WATCH_NS        = (NUM_ROWS * 400 + TB_DEAD_TIMEOUT) * 4;
  localparam logic [23:0] BG_ADDR         = 24'h008004;   // LoROM ROM, read around MCU ops

  typedef enum logic [2:0] {op_crd, op_cwr, op_mrd, op_mwr, op_idle} op_e;

  typedef struct packed {
    op_e         op;
    logic        bg;        // Console keeps running during an MCU op
    mapper_e     mapper;
    logic [23:0] addr;
    logic [7:0]  data;
    logic        exp_oe_n;
  } row_t;

  logic CLK2 = 1'b0;
  logic rst_n;
  logic [23:0] snes_addr;
  logic snes_read_n, snes_write_n, snes_cpu_clk, snes_cs_n;
  logic [7:0] snes_data_in, snes_data_out, mcu_rdata;
  logic snes_data_oe, snes_databus_oe_n, snes_databus_dir, mcu_rdy;
  map_cfg_t map_cfg;
  mcu_req_t mcu_req;
  logic [`ROM_ADDR_W-1:0] rom_addr;
  rom_word_u rom_wdata, rom_rdata;
  logic rom_data_oe, rom_we_n, rom_bhe_n, rom_ble_n;

  row_t rows [NUM_ROWS];
  logic [7:0] shadow [logic [23:0]];   // Expected PSRAM bytes
  int byte_errs, word_errs, flag_errs, other_errs;

  always #2 CLK2 = ~CLK2;

  mem_ctrl_top #(.DEAD_TIMEOUT(TB_DEAD_TIMEOUT)) uut (
    .CLK2(CLK2), .rst_n(rst_n),
    .snes_addr_in(snes_addr), .snes_read_n_in(snes_read_n),
    .snes_write_n_in(snes_write_n), .snes_cpu_clk_in(snes_cpu_clk),
    .snes_cs_n(snes_cs_n), .snes_data_in(snes_data_in),
    .snes_data_out(snes_data_out), .snes_data_oe(snes_data_oe),
    .snes_databus_oe_n(snes_databus_oe_n), .snes_databus_dir(snes_databus_dir),
    .map_cfg(map_cfg), .mcu_req(mcu_req), .mcu_rdy(mcu_rdy), .mcu_rdata(mcu_rdata),
    .rom_addr(rom_addr), .rom_wdata(rom_wdata), .rom_rdata(rom_rdata),
    .rom_data_oe(rom_data_oe), .rom_we_n(rom_we_n),
    .rom_bhe_n(rom_bhe_n), .rom_ble_n(rom_ble_n)
  );

  psram_model psram (
    .CLK2(CLK2), .addr(rom_addr), .wdata(rom_wdata), .we_n(rom_we_n),
    .bhe_n(rom_bhe_n), .ble_n(rom_ble_n), .rdata(rom_rdata)
  );

  //////////////////////////////////////////////////////////////////////
  // Expected values
  //////////////////////////////////////////////////////////////////////

  // Console address to PSRAM byte address, returns the hit
  function automatic logic map_console(input mapper_e m, input logic [23:0] a,
                                       output logic [23:0] ba, output logic sram);
    logic [7:0] bank;
    bank = a[23:16];
    ba   = '0;
    if (m == map_lorom) begin
      sram = ((bank >= 8'h70 && bank <= 8'h7D) || bank >= 8'hF0) && !a[15];
      if (sram) ba = `SAVERAM_BASE + ({5'd0, bank[3:0], a[14:0]} & map_cfg.saveram_mask);
      else if (a[15]) ba = {2'b00, bank[6:0], a[14:0]} & map_cfg.rom_mask;
      return sram | a[15];
    end
    sram = (bank[6:5] == 2'b01) && (a[15:13] == 3'b011);   // 20-3F, A0-BF
    if (sram) ba = `SAVERAM_BASE + ({6'd0, bank[4:0], a[12:0]} & map_cfg.saveram_mask);
    else ba = {2'b00, a[21:0]} & map_cfg.rom_mask;
    return sram | ((a[22] | a[15]) && bank[7:1] != 7'b0111111);
  endfunction

  function automatic rom_word_u shadow_word(input logic [23:0] ba);
    rom_word_u w;
    w.lanes.hi = shadow[{ba[23:1], 1'b0}];
    w.lanes.lo = shadow[{ba[23:1], 1'b1}];
    return w;
  endfunction

  // Random word under a byte address, once per word
  task automatic preload(input logic [23:0] ba);
    logic [15:0] w;
    if (!shadow.exists({ba[23:1], 1'b0})) begin
      w = 16'($urandom);
      psram.poke_word(ba[23:1], w);
      shadow[{ba[23:1], 1'b0}] = w[15:8];
      shadow[{ba[23:1], 1'b1}] = w[7:0];
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      byte_errs++;
    end
  endtask

  task automatic check_word(input string name, input rom_word_u got, input rom_word_u exp);
    if (got.word !== exp.word) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got.word, exp.word);
      word_errs++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      flag_errs++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bus drivers
  //////////////////////////////////////////////////////////////////////

  // One slow console cycle, each phase far longer than the synchronizer
  task automatic console_cycle(input logic [23:0] a, input logic wr, input logic [7:0] d,
                               input logic exp_oe_n);
    logic [23:0] ba;
    logic sram;
    logic hit;
    @(posedge CLK2);
    hit = map_console(map_cfg.mapper, a, ba, sram);
    snes_addr    <= a;
    snes_data_in <= d;
    snes_cs_n    <= 1'b0;
    repeat (12) @(posedge CLK2);
    if (wr) snes_write_n <= 1'b0;
    else snes_read_n <= 1'b0;
    repeat (12) @(posedge CLK2);
    snes_cpu_clk <= 1'b1;
    repeat (14) @(posedge CLK2);
    @(negedge CLK2);
    check_flag("snes_databus_oe_n", snes_databus_oe_n, exp_oe_n);
    if (!wr) begin
      check_flag("snes_databus_dir", snes_databus_dir, 1'b1);
      check_flag("snes_data_oe", snes_data_oe, hit);
      if (hit) check_byte("snes_data_out", snes_data_out, shadow[ba]);
    end else begin
      check_flag("snes_databus_dir", snes_databus_dir, 1'b0);
      check_flag("rom_data_oe", rom_data_oe, hit);
      check_flag("rom_we_n", rom_we_n, !sram);
    end
    @(posedge CLK2);
    snes_cpu_clk <= 1'b0;
    repeat (4) @(posedge CLK2);
    snes_read_n  <= 1'b1;
    snes_write_n <= 1'b1;
    snes_cs_n    <= 1'b1;
    repeat (12) @(posedge CLK2);
    if (wr && sram) shadow[ba] = d;
    if (wr && hit) check_word("psram word", 16'(psram.peek_word(ba[23:1])), shadow_word(ba));
  endtask

  task automatic mcu_access(input row_t r);
    int tries;
    @(posedge CLK2);
    mcu_req <= '{rrq: r.op == op_mrd, wrq: r.op == op_mwr, addr: r.addr, wdata: r.data};
    @(posedge CLK2);
    mcu_req <= '0;
    @(negedge CLK2);
    check_flag("mcu_rdy", mcu_rdy, 1'b0);
    tries = 0;
    while (!mcu_rdy && tries < 200) begin
      if (r.bg) console_cycle(BG_ADDR, 1'b0, 8'h00, 1'b0);
      else @(negedge CLK2);
      tries++;
    end
    if (!mcu_rdy) begin
      $display("MCU access at %h never completed", r.addr);
      other_errs++;
    end else if (r.op == op_mrd) begin
      check_byte("mcu_rdata", mcu_rdata, shadow[r.addr]);
    end else begin
      shadow[r.addr] = r.data;
      check_word("psram word", 16'(psram.peek_word(r.addr[23:1])), shadow_word(r.addr));
    end
  endtask

  task automatic load_table();
    rows[0]  = '{op_mwr,  1'b0, map_lorom, 24'h001234, 8'h5A, 1'b1};
    rows[1]  = '{op_mwr,  1'b0, map_lorom, 24'h001235, 8'hC3, 1'b1};
    rows[2]  = '{op_mrd,  1'b0, map_lorom, 24'h001234, 8'h00, 1'b1};
    rows[3]  = '{op_mrd,  1'b0, map_lorom, 24'h001235, 8'h00, 1'b1};
    rows[4]  = '{op_crd,  1'b0, map_lorom, 24'h008000, 8'h00, 1'b0};
    rows[5]  = '{op_crd,  1'b0, map_lorom, 24'h019ABD, 8'h00, 1'b0};
    rows[6]  = '{op_crd,  1'b0, map_hirom, 24'hC01234, 8'h00, 1'b0};
    rows[7]  = '{op_crd,  1'b0, map_hirom, 24'h405679, 8'h00, 1'b0};
    rows[8]  = '{op_cwr,  1'b0, map_lorom, 24'h700010, 8'h77, 1'b0};
    rows[9]  = '{op_crd,  1'b0, map_lorom, 24'h700010, 8'h00, 1'b0};
    rows[10] = '{op_cwr,  1'b0, map_hirom, 24'h206011, 8'h99, 1'b0};
    rows[11] = '{op_cwr,  1'b0, map_lorom, 24'h008002, 8'hEE, 1'b0};
    rows[12] = '{op_mrd,  1'b1, map_lorom, 24'h008001, 8'h00, 1'b1};
    rows[13] = '{op_mwr,  1'b1, map_lorom, 24'h002000, 8'h3C, 1'b1};
    rows[14] = '{op_crd,  1'b0, map_lorom, 24'h7E1234, 8'h00, 1'b1};  // Unmapped
    rows[15] = '{op_idle, 1'b0, map_lorom, 24'h000000, 8'h00, 1'b1};
    rows[16] = '{op_mrd,  1'b0, map_lorom, 24'h002000, 8'h00, 1'b1};
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [23:0] ba;
    logic sram;
    void'($urandom(35904));
    rst_n = 1'b0;
    snes_addr = '0;
    snes_read_n = 1'b1;
    snes_write_n = 1'b1;
    snes_cpu_clk = 1'b0;
    snes_cs_n = 1'b1;
    snes_data_in = '0;
    mcu_req = '0;
    map_cfg = '{mapper: map_lorom, rom_mask: 24'h3FFFFF, saveram_mask: 24'h007FFF};
    byte_errs = 0;
    word_errs = 0;
    flag_errs = 0;
    other_errs = 0;
    load_table();
    preload(BG_ADDR - 24'h008000);
    foreach (rows[i]) begin
      if (rows[i].op == op_mrd || rows[i].op == op_mwr) preload(rows[i].addr);
      else if (map_console(rows[i].mapper, rows[i].addr, ba, sram)) preload(ba);
    end
    repeat (4) @(posedge CLK2);
    rst_n <= 1'b1;
    repeat (2) @(negedge CLK2);
    check_flag("mcu_rdy", mcu_rdy, 1'b1);
    check_flag("rom_we_n", rom_we_n, 1'b1);
    check_flag("rom_data_oe", rom_data_oe, 1'b0);
    check_flag("snes_data_oe", snes_data_oe, 1'b0);
    check_flag("snes_databus_oe_n", snes_databus_oe_n, 1'b1);
    foreach (rows[i]) begin
      @(posedge CLK2);
      map_cfg.mapper <= rows[i].mapper;
      case (rows[i].op)
        op_crd:  console_cycle(rows[i].addr, 1'b0, 8'h00, rows[i].exp_oe_n);
        op_cwr:  console_cycle(rows[i].addr, 1'b1, rows[i].data, rows[i].exp_oe_n);
        op_idle: repeat (TB_DEAD_TIMEOUT + 100) @(posedge CLK2);   // Console goes dead
        default: mcu_access(rows[i]);
      endcase
    end
    $display("Errors: byte %0d, word %0d, flag %0d, other %0d",
             byte_errs, word_errs, flag_errs, other_errs);
    if (byte_errs + word_errs + flag_errs + other_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCH_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCH_NS);
    $display("Checks failed");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+include
design/mem_ctrl_pkg.sv
design/snes_bus_sync.sv
design/snes_alive_monitor.sv
design/snes_addr_map.sv
design/mcu_rom_arbiter.sv
design/psram_bus_mux.sv
design/mem_ctrl_top.sv
tests/psram_model.sv
tests/tb_mem_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the memory controller testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -Wno-fatal \
  -f flist.f \
  --top-module tb_mem_ctrl \
  -o Vtb_mem_ctrl

./obj_dir/Vtb_mem_ctrl | tee "$LOG"

if grep -q "Checks failed" "$LOG"; then
  echo "Simulation FAILED"
  exit 1
fi
echo "Simulation PASSED"
